// File: hdl/pw_params.svh
`ifndef PW_PARAMS_SVH
`define PW_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// sizes shared by the sniffer trigger block
////////////////////////////////////////////////////////////////////////////

// one usb byte, also the register port data width
`define PW_DATA_W        8

// bytes in the match pattern and in the packet history
`define PW_PATTERN_BYTES 4

// capture buffer entries, power of two
`define PW_FIFO_DEPTH    16

// delay, width and timer counter
`define PW_COUNT_W       8

// host register address
`define PW_ADDR_W        4

`endif

// File: hdl/pw_reg_pkg.sv
`include "pw_params.svh"

package pw_reg_pkg;

   // host register map
   typedef enum logic [`PW_ADDR_W-1:0] {
      REG_PATTERN = 4'h0,   // shift in newest pattern byte
      REG_MASK    = 4'h1,   // shift in newest mask byte
      REG_DELAY   = 4'h2,
      REG_WIDTH   = 4'h3,
      REG_ARM     = 4'h4,   // bit 0: 1 arms, 0 disarms
      REG_STATUS  = 4'h5,   // read only
      REG_FIFO    = 4'h6    // read pops one captured byte
   } pw_reg_e;

   // status byte layout
   localparam int unsigned STAT_ARMED     = 0;
   localparam int unsigned STAT_TRIGGERED = 1;
   localparam int unsigned STAT_EMPTY     = 2;
   localparam int unsigned STAT_FULL      = 3;

endpackage

// File: hdl/pw_trig_pkg.sv
package pw_trig_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // trigger sequencing
   ////////////////////////////////////////////////////////////////////////////

   // IDLE -> ARMED on arm, ARMED -> DELAY on match,
   // DELAY -> PULSE and PULSE -> DONE on timer expiry
   typedef enum logic [2:0] {
      TRIG_IDLE  = 3'd0,
      TRIG_ARMED = 3'd1,   // waiting for a pattern match
      TRIG_DELAY = 3'd2,   // counting the programmed delay
      TRIG_PULSE = 3'd3,   // cw trigger output high
      TRIG_DONE  = 3'd4    // one shot spent, wait for re-arm
   } trig_state_e;

endpackage

// File: hdl/pw_ctrl_if.sv
`timescale 1ns/1ns
`include "pw_params.svh"

// trigger control from the register block
interface pw_ctrl_if;

   logic                   arm;      // one-cycle strobe
   logic                   disarm;   // one-cycle strobe
   logic [`PW_COUNT_W-1:0] delay;
   logic [`PW_COUNT_W-1:0] width;

   modport regs (
      output arm,
      output disarm,
      output delay,
      output width
   );

   modport fsm (
      input arm,
      input disarm,
      input delay,
      input width
   );

   // the timer only needs the phase lengths
   modport timer (
      input delay,
      input width
   );

endinterface

// File: hdl/pw_regs.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module pw_regs
   import pw_reg_pkg::*, pw_trig_pkg::*;
(
   input  logic                                    fe_clk_i,
   input  logic                                    rst_n_i,
   input  logic                                    reg_wr_i,
   input  logic                                    reg_rd_i,
   input  logic [`PW_ADDR_W-1:0]                   reg_addr_i,
   input  logic [`PW_DATA_W-1:0]                   reg_wdata_i,
   output logic [`PW_DATA_W-1:0]                   reg_rdata_o,
   output logic                                    reg_rvalid_o,
   input  trig_state_e                             state_i,
   input  logic                                    triggered_i,
   output logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] pattern_o,
   output logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] mask_o,
   output logic                                    fifo_pop_o,
   output logic                                    fifo_clear_o,
   input  logic [`PW_DATA_W-1:0]                   fifo_data_i,
   input  logic                                    fifo_empty_i,
   input  logic                                    fifo_full_i,
   pw_ctrl_if.regs                                 ctrl
);

   localparam int PAT_W = `PW_PATTERN_BYTES * `PW_DATA_W;

   pw_reg_e                addr;
   logic                   wr_arm;
   logic                   armed;
   logic [`PW_DATA_W-1:0]  status;
   logic [PAT_W-1:0]       pattern_q;
   logic [PAT_W-1:0]       mask_q;
   logic [`PW_COUNT_W-1:0] delay_q;
   logic [`PW_COUNT_W-1:0] width_q;

   assign addr   = pw_reg_e'(reg_addr_i);
   assign wr_arm = reg_wr_i && (addr == REG_ARM);

   // trigger control strobes, decoded straight off the write
   assign ctrl.arm      = wr_arm && reg_wdata_i[0];
   assign ctrl.disarm   = wr_arm && !reg_wdata_i[0];
   assign ctrl.delay    = delay_q;
   assign ctrl.width    = width_q;
   assign fifo_clear_o  = ctrl.arm;   // fresh capture on every arm
   assign fifo_pop_o    = reg_rd_i && (addr == REG_FIFO);

   assign pattern_o = pattern_q;
   assign mask_o    = mask_q;

   assign armed = (state_i == TRIG_ARMED) || (state_i == TRIG_DELAY) ||
                  (state_i == TRIG_PULSE);

   always_comb begin
      status                 = '0;
      status[STAT_ARMED]     = armed;
      status[STAT_TRIGGERED] = triggered_i;
      status[STAT_EMPTY]     = fifo_empty_i;
      status[STAT_FULL]      = fifo_full_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         pattern_q <= '0;
         mask_q    <= '0;
         delay_q   <= '0;
         width_q   <= `PW_COUNT_W'(1);
      end else if (reg_wr_i) begin
         case (addr)
            // newest byte enters at the bottom
            REG_PATTERN: pattern_q <= {pattern_q[PAT_W-`PW_DATA_W-1:0], reg_wdata_i};
            REG_MASK:    mask_q    <= {mask_q[PAT_W-`PW_DATA_W-1:0], reg_wdata_i};
            REG_DELAY:   delay_q   <= reg_wdata_i;
            REG_WIDTH:   width_q   <= reg_wdata_i;
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read side, data one cycle after the strobe
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         reg_rvalid_o <= 1'b0;
      end else begin
         reg_rvalid_o <= reg_rd_i;
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (reg_rd_i) begin
         case (addr)
            REG_PATTERN: reg_rdata_o <= pattern_q[`PW_DATA_W-1:0];  // newest byte
            REG_MASK:    reg_rdata_o <= mask_q[`PW_DATA_W-1:0];
            REG_DELAY:   reg_rdata_o <= delay_q;
            REG_WIDTH:   reg_rdata_o <= width_q;
            REG_ARM:     reg_rdata_o <= {{(`PW_DATA_W-1){1'b0}}, armed};
            REG_STATUS:  reg_rdata_o <= status;
            REG_FIFO:    reg_rdata_o <= fifo_data_i;   // head byte, popped this edge
            default:     reg_rdata_o <= '0;
         endcase
      end
   end

endmodule

// File: hdl/pattern_matcher.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module pattern_matcher (
   input  logic                                    fe_clk_i,
   input  logic                                    rst_n_i,
   input  logic [`PW_DATA_W-1:0]                   fe_data_i,
   input  logic                                    fe_rxvalid_i,
   input  logic                                    fe_rxactive_i,
   input  logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] pattern_i,
   input  logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] mask_i,
   output logic                                    match_o
);

   localparam int HIST_W = `PW_PATTERN_BYTES * `PW_DATA_W;
   localparam int CNT_W  = $clog2(`PW_PATTERN_BYTES + 1);

   logic [HIST_W-1:0] hist_q;
   logic [HIST_W-1:0] hist_next;
   logic [CNT_W-1:0]  count_q;   // bytes seen this packet, saturating
   logic              accept;
   logic              enough;
   logic              hit;

   assign accept    = fe_rxvalid_i && fe_rxactive_i;
   assign hist_next = {hist_q[HIST_W-`PW_DATA_W-1:0], fe_data_i};

   // the incoming byte completes a full window
   assign enough = count_q >= CNT_W'(`PW_PATTERN_BYTES - 1);

   // only masked bits take part
   assign hit = ((hist_next ^ pattern_i) & mask_i) == '0;

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         hist_q  <= '0;
         count_q <= '0;
         match_o <= 1'b0;
      end else if (!fe_rxactive_i) begin
         hist_q  <= '0;   // packet boundary
         count_q <= '0;
         match_o <= 1'b0;
      end else begin
         match_o <= accept && enough && hit;
         if (accept) begin
            hist_q <= hist_next;
            if (count_q != CNT_W'(`PW_PATTERN_BYTES)) begin
               count_q <= count_q + 1'b1;
            end
         end
      end
   end

endmodule

// File: hdl/trigger_fsm.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module trigger_fsm
   import pw_trig_pkg::*;
(
   input  logic        fe_clk_i,
   input  logic        rst_n_i,
   input  logic        match_i,
   input  logic        timer_done_i,
   pw_ctrl_if.fsm      ctrl,
   output logic        timer_start_o,
   output logic        timer_sel_o,   // 1 = width phase
   output logic        capture_en_o,
   output trig_state_e state_o,
   output logic        triggered_o,
   output logic        cw_trig_o
);

   trig_state_e state_q;
   trig_state_e state_d;
   logic        start_q;      // delay phase start, one cycle after the match
   logic        delay_done;
   logic        width_start;
   logic        fire;
   logic        arm_taken;

   // a stale done in the start cycle comes from an abandoned run
   assign delay_done  = (state_q == TRIG_DELAY) && timer_done_i && !start_q;
   // width load overlaps the delay expiry so the pulse has no gap
   assign width_start = delay_done && !ctrl.disarm;

   assign timer_start_o = start_q || width_start;
   assign timer_sel_o   = width_start;

   assign fire      = (state_q == TRIG_ARMED) && (state_d == TRIG_DELAY);
   assign arm_taken = ctrl.arm && (state_q != TRIG_DELAY) && (state_q != TRIG_PULSE);

   always_comb begin
      state_d = state_q;
      case (state_q)
         TRIG_IDLE:  if (ctrl.arm)     state_d = TRIG_ARMED;
         TRIG_ARMED: if (match_i)      state_d = TRIG_DELAY;
         TRIG_DELAY: if (delay_done)   state_d = TRIG_PULSE;
         TRIG_PULSE: if (timer_done_i) state_d = TRIG_DONE;
         TRIG_DONE:  if (ctrl.arm)     state_d = TRIG_ARMED;
         default:                      state_d = TRIG_IDLE;
      endcase
      if (ctrl.disarm) begin
         state_d = TRIG_IDLE;   // from anywhere
      end
   end

   // capture includes the byte right after the pattern
   assign capture_en_o = (state_q == TRIG_DELAY) || (state_q == TRIG_PULSE) ||
                         (state_q == TRIG_DONE) || ((state_q == TRIG_ARMED) && match_i);

   assign state_o = state_q;

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         state_q     <= TRIG_IDLE;
         start_q     <= 1'b0;
         triggered_o <= 1'b0;
         cw_trig_o   <= 1'b0;
      end else begin
         state_q   <= state_d;
         start_q   <= fire;
         cw_trig_o <= (state_d == TRIG_PULSE);   // tracks the pulse state exactly
         if (fire) begin
            triggered_o <= 1'b1;
         end else if (arm_taken) begin
            triggered_o <= 1'b0;
         end
      end
   end

endmodule

// File: hdl/trigger_timer.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module trigger_timer (
   input  logic    fe_clk_i,
   input  logic    rst_n_i,
   input  logic    start_i,
   input  logic    sel_i,   // 0 delay, 1 width
   pw_ctrl_if.timer ctrl,
   output logic    done_o
);

   logic [`PW_COUNT_W-1:0] width_floor;
   logic [`PW_COUNT_W-1:0] load_val;
   logic [`PW_COUNT_W-1:0] count_q;
   logic                   busy_q;

   assign width_floor = (ctrl.width == '0) ? `PW_COUNT_W'(1) : ctrl.width;

   // width is started in the last delay cycle, that cycle counts as one
   assign load_val = sel_i ? (width_floor - `PW_COUNT_W'(1)) : ctrl.delay;

   assign done_o = busy_q && (count_q == '0);

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
         busy_q  <= 1'b0;
      end else if (start_i) begin
         count_q <= load_val;   // restart wins over a running count
         busy_q  <= 1'b1;
      end else if (busy_q) begin
         if (count_q == '0) begin
            busy_q <= 1'b0;
         end else begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

// File: hdl/capture_fifo.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module capture_fifo (
   input  logic                  fe_clk_i,
   input  logic                  rst_n_i,
   input  logic                  capture_en_i,
   input  logic [`PW_DATA_W-1:0] fe_data_i,
   input  logic                  fe_rxvalid_i,
   input  logic                  fe_rxactive_i,
   input  logic                  pop_i,
   input  logic                  clear_i,
   output logic [`PW_DATA_W-1:0] pop_data_o,
   output logic                  empty_o,
   output logic                  full_o
);

   localparam int         AW    = $clog2(`PW_FIFO_DEPTH);
   localparam logic [AW:0] DEPTH = `PW_FIFO_DEPTH;

   logic [`PW_DATA_W-1:0] mem [`PW_FIFO_DEPTH];
   logic [AW-1:0]         wr_ptr_q;
   logic [AW-1:0]         rd_ptr_q;
   logic [AW:0]           fill_q;
   logic                  wr_en;
   logic                  rd_en;

   assign empty_o = (fill_q == '0);
   assign full_o  = (fill_q == DEPTH);

   // excess bytes are simply lost once full
   assign wr_en = capture_en_i && fe_rxvalid_i && fe_rxactive_i && !full_o && !clear_i;
   assign rd_en = pop_i && !empty_o && !clear_i;

   assign pop_data_o = empty_o ? '0 : mem[rd_ptr_q];   // oldest byte

   always_ff @(posedge fe_clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= fe_data_i;
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
      end else begin
         if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
         if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase
      end
   end

endmodule

// File: hdl/phywhisperer_top.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module phywhisperer_top
   import pw_trig_pkg::*;
(
   input  logic                  fe_clk_i,
   input  logic                  rst_n_i,
   input  logic                  reg_wr_i,
   input  logic                  reg_rd_i,
   input  logic [`PW_ADDR_W-1:0] reg_addr_i,
   input  logic [`PW_DATA_W-1:0] reg_wdata_i,
   output logic [`PW_DATA_W-1:0] reg_rdata_o,
   output logic                  reg_rvalid_o,
   input  logic [`PW_DATA_W-1:0] fe_data_i,
   input  logic                  fe_rxvalid_i,
   input  logic                  fe_rxactive_i,
   output logic                  cw_trig_o
);

   logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] pattern;
   logic [`PW_PATTERN_BYTES*`PW_DATA_W-1:0] mask;
   logic                                    fifo_pop;
   logic                                    fifo_clear;
   logic [`PW_DATA_W-1:0]                   pop_data;
   logic                                    empty;
   logic                                    full;
   logic                                    match;
   logic                                    timer_start;
   logic                                    timer_sel;
   logic                                    timer_done;
   logic                                    capture_en;
   logic                                    triggered;
   trig_state_e                             state;

   pw_ctrl_if ctrl_if ();

   ////////////////////////////////////////////////////////////////////////////
   // host registers
   ////////////////////////////////////////////////////////////////////////////

   pw_regs u_pw_regs (
      .fe_clk_i     (fe_clk_i),
      .rst_n_i      (rst_n_i),
      .reg_wr_i     (reg_wr_i),
      .reg_rd_i     (reg_rd_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_rdata_o  (reg_rdata_o),
      .reg_rvalid_o (reg_rvalid_o),
      .state_i      (state),
      .triggered_i  (triggered),
      .pattern_o    (pattern),
      .mask_o       (mask),
      .fifo_pop_o   (fifo_pop),
      .fifo_clear_o (fifo_clear),
      .fifo_data_i  (pop_data),
      .fifo_empty_i (empty),
      .fifo_full_i  (full),
      .ctrl         (ctrl_if.regs)
   );

   ////////////////////////////////////////////////////////////////////////////
   // match, trigger and capture
   ////////////////////////////////////////////////////////////////////////////

   pattern_matcher u_pattern_matcher (
      .fe_clk_i      (fe_clk_i),
      .rst_n_i       (rst_n_i),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .pattern_i     (pattern),
      .mask_i        (mask),
      .match_o       (match)
   );

   trigger_fsm u_trigger_fsm (
      .fe_clk_i      (fe_clk_i),
      .rst_n_i       (rst_n_i),
      .match_i       (match),
      .timer_done_i  (timer_done),
      .ctrl          (ctrl_if.fsm),
      .timer_start_o (timer_start),
      .timer_sel_o   (timer_sel),
      .capture_en_o  (capture_en),
      .state_o       (state),
      .triggered_o   (triggered),
      .cw_trig_o     (cw_trig_o)
   );

   trigger_timer u_trigger_timer (
      .fe_clk_i (fe_clk_i),
      .rst_n_i  (rst_n_i),
      .start_i  (timer_start),
      .sel_i    (timer_sel),
      .ctrl     (ctrl_if.timer),
      .done_o   (timer_done)
   );

   capture_fifo u_capture_fifo (
      .fe_clk_i      (fe_clk_i),
      .rst_n_i       (rst_n_i),
      .capture_en_i  (capture_en),
      .fe_data_i     (fe_data_i),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .fe_rxactive_i (fe_rxactive_i),
      .pop_i         (fifo_pop),
      .clear_i       (fifo_clear),
      .pop_data_o    (pop_data),
      .empty_o       (empty),
      .full_o        (full)
   );

endmodule

// File: sim/pw_asserts.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module pw_asserts
   import pw_trig_pkg::*;
(
   input logic                                    clk_i,
   input logic                                    rst_n_i,
   input trig_state_e                             state_i,
   input logic                                    cw_trig_i,
   input logic [`PW_COUNT_W-1:0]                  width_i,
   input logic [$clog2(`PW_FIFO_DEPTH)-1:0]       fifo_wr_ptr_i,
   input logic                                    fifo_clear_i,
   input logic                                    fifo_full_i,
   input logic                                    reg_rd_i,
   input logic                                    reg_rvalid_i
);

   logic [`PW_COUNT_W:0] run_q;   // high cycles seen so far in this pulse
   logic [`PW_COUNT_W:0] width_floor;

   assign width_floor = (width_i == '0) ? (`PW_COUNT_W+1)'(1) : {1'b0, width_i};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         run_q <= '0;
      end else begin
         run_q <= cw_trig_i ? run_q + 1'b1 : '0;
      end
   end

   a_trig_in_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cw_trig_i |-> state_i == TRIG_PULSE) else $error("cw trigger outside pulse state");

   a_trig_width: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cw_trig_i |-> run_q < width_floor) else $error("cw trigger longer than width");

   // write pointer frozen while full unless cleared
   a_no_wr_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fifo_full_i && !fifo_clear_i |=> $stable(fifo_wr_ptr_i))
      else $error("capture write while full");

   a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      reg_rd_i |=> reg_rvalid_i) else $error("read data valid missing");

   a_rvalid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      reg_rvalid_i |-> $past(reg_rd_i)) else $error("read data valid without read");

endmodule

bind phywhisperer_top pw_asserts u_pw_asserts (
   .clk_i         (fe_clk_i),
   .rst_n_i       (rst_n_i),
   .state_i       (state),
   .cw_trig_i     (cw_trig_o),
   .width_i       (u_pw_regs.width_q),
   .fifo_wr_ptr_i (u_capture_fifo.wr_ptr_q),
   .fifo_clear_i  (fifo_clear),
   .fifo_full_i   (full),
   .reg_rd_i      (reg_rd_i),
   .reg_rvalid_i  (reg_rvalid_o)
);

// File: sim/tb_phywhisperer.sv
`timescale 1ns/1ns
`include "pw_params.svh"

module tb_phywhisperer
   import pw_reg_pkg::*;
();

   localparam int CYCLE_LIMIT = 40 * 200 + 5000;   // packets x max packet cycles + margin

   logic       fe_clk_i;
   logic       rst_n_i;
   logic       reg_wr_i;
   logic       reg_rd_i;
   logic [3:0] reg_addr_i;
   logic [7:0] reg_wdata_i;
   logic [7:0] reg_rdata_o;
   logic       reg_rvalid_o;
   logic [7:0] fe_data_i;
   logic       fe_rxvalid_i;
   logic       fe_rxactive_i;
   logic       cw_trig_o;

   int seed = 32'h2242;
   int cyc = 0;
   int errors = 0;
   int timeouts = 0;

   // reference model state, 0 idle, 1 armed, 2 fired
   int         m_state = 0;
   logic [31:0] m_pat = '0;
   logic [31:0] m_mask = '0;
   logic [31:0] m_hist = '0;
   int         m_cnt = 0;
   logic [7:0] m_delay = 8'd0;
   logic [7:0] m_width = 8'd1;
   logic       m_trig = 1'b0;
   int         m_fires = 0;
   logic [7:0] m_q[$];
   int         exp_rise[$];
   int         exp_len[$];

   // pulse monitor
   int   rises[$];
   int   lens[$];
   int   pulses = 0;
   int   run = 0;
   logic cw_prev = 1'b0;

   phywhisperer_top u_phywhisperer_top (.*);

   always #5 fe_clk_i = ~fe_clk_i;

   always @(posedge fe_clk_i) begin
      cyc <= cyc + 1;
      if (cyc > CYCLE_LIMIT) begin
         $display("timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("errors: %0d mismatches, %0d timeouts", errors, timeouts + 1);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   always @(negedge fe_clk_i) begin
      if (cw_trig_o) begin
         if (!cw_prev) begin
            rises.push_back(cyc);   // edge index of the rise
            pulses++;
         end
         run++;
      end else if (cw_prev) begin
         lens.push_back(run);
         run = 0;
      end
      cw_prev = cw_trig_o;
   end

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [7:0] rand_byte();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // host register access
   ////////////////////////////////////////////////////////////////////////////

   task automatic wr_reg(input pw_reg_e addr, input logic [7:0] data);
      int edge_n;
      edge_n = cyc + 1;
      reg_wr_i    = 1'b1;
      reg_addr_i  = addr;
      reg_wdata_i = data;
      case (addr)
         REG_PATTERN: m_pat = {m_pat[23:0], data};
         REG_MASK:    m_mask = {m_mask[23:0], data};
         REG_DELAY:   m_delay = data;
         REG_WIDTH:   m_width = data;
         REG_ARM: begin
            if (data[0]) begin
               m_state = 1;
               m_trig  = 1'b0;
               m_q.delete();   // arm clears the capture
            end else begin
               // disarm on or before the rise edge cancels the pending pulse
               if (m_state == 2 && exp_rise.size() > 0 && exp_rise[$] >= edge_n) begin
                  void'(exp_rise.pop_back());
                  void'(exp_len.pop_back());
                  m_fires--;
               end
               m_state = 0;
            end
         end
         default: ;
      endcase
      @(negedge fe_clk_i);
      reg_wr_i = 1'b0;
   endtask

   task automatic rd_reg(input pw_reg_e addr, output logic [7:0] data);
      int n;
      reg_rd_i   = 1'b1;
      reg_addr_i = addr;
      @(negedge fe_clk_i);
      reg_rd_i = 1'b0;
      n = 0;
      while (!reg_rvalid_o && n < 4) begin
         @(negedge fe_clk_i);
         n++;
      end
      if (!reg_rvalid_o) begin
         $display("timeout: no read data valid after a register read");
         timeouts++;
      end
      data = reg_rdata_o;
   endtask

   task automatic check_status();
      logic [7:0] d;
      logic [7:0] exp;
      exp = {4'h0, m_q.size() == 16, m_q.size() == 0, m_trig, m_state == 1};
      rd_reg(REG_STATUS, d);
      check_eq("status", d, exp);
   endtask

   task automatic pop_check();
      logic [7:0] d;
      logic [7:0] exp;
      exp = (m_q.size() > 0) ? m_q.pop_front() : 8'h00;   // empty pops read 0
      rd_reg(REG_FIFO, d);
      check_eq("fifo byte", d, exp);
   endtask

   task automatic drain_check();
      int n;
      n = m_q.size();
      repeat (n) pop_check();
      check_status();
      pop_check();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // usb byte stream and model
   ////////////////////////////////////////////////////////////////////////////

   task automatic model_accept(input logic [7:0] d, input int edge_n);
      logic hit;
      if (m_state == 2 && m_q.size() < 16) m_q.push_back(d);
      m_hist = {m_hist[23:0], d};
      if (m_cnt < 4) m_cnt++;
      // any masked bit that differs from the pattern breaks the match
      hit = 1'b1;
      for (int i = 0; i < 32; i++) begin
         if (m_mask[i] && (m_hist[i] != m_pat[i])) hit = 1'b0;
      end
      if (m_state == 1 && m_cnt >= 4 && hit) begin
         m_state = 2;
         m_trig  = 1'b1;
         m_fires++;
         exp_rise.push_back(edge_n + m_delay + 3);
         exp_len.push_back((m_width == 0) ? 1 : m_width);
      end
   endtask

   task automatic send_byte(input logic [7:0] d);
      int r;
      r = $random(seed);
      fe_rxactive_i = 1'b1;
      if (r[1:0] == 2'b00) begin   // valid gap
         fe_rxvalid_i = 1'b0;
         @(negedge fe_clk_i);
      end
      fe_rxvalid_i = 1'b1;
      fe_data_i    = d;
      model_accept(d, cyc + 1);
      @(negedge fe_clk_i);
      fe_rxvalid_i = 1'b0;
   endtask

   task automatic end_packet();
      fe_rxactive_i = 1'b0;
      fe_rxvalid_i  = 1'b0;
      m_hist = '0;
      m_cnt  = 0;
      repeat (2) @(negedge fe_clk_i);
   endtask

   task automatic send_pat(input int lo, input int hi);
      for (int k = lo; k <= hi; k++) send_byte(m_pat[31-8*k -: 8]);
   endtask

   task automatic send_packet(input int pre, input logic embed, input int post);
      repeat (pre) send_byte(rand_byte());
      if (embed) send_pat(0, 3);
      repeat (post) send_byte(rand_byte());
      end_packet();
   endtask

   // wait for expected pulses, then a quiet window for unexpected ones
   task automatic settle();
      int n;
      n = 0;
      while ((pulses < m_fires || cw_trig_o) && n < 400) begin
         @(negedge fe_clk_i);
         n++;
      end
      if (n >= 400) begin
         $display("timeout: trigger pulse did not arrive or did not end");
         timeouts++;
      end
      repeat (m_delay + m_width + 8) @(negedge fe_clk_i);
      check_eq("pulse count", pulses, m_fires);
      while (lens.size() > 0 && exp_rise.size() > 0) begin
         check_eq("cw_trig_o rise edge", rises.pop_front(), exp_rise.pop_front());
         check_eq("cw_trig_o width", lens.pop_front(), exp_len.pop_front());
      end
      rises.delete();
      lens.delete();
   endtask

   task automatic load_random_setup();
      int r;
      repeat (4) wr_reg(REG_PATTERN, rand_byte());
      repeat (4) wr_reg(REG_MASK, rand_byte());
      r = $random(seed);
      wr_reg(REG_DELAY, 8'(r[7:0] % 24));
      r = $random(seed);
      wr_reg(REG_WIDTH, 8'(r[7:0] % 9));
   endtask

   initial begin
      logic [7:0] d;
      int r;
      fe_clk_i = 1'b0;
      rst_n_i = 1'b0;
      reg_wr_i = 1'b0;
      reg_rd_i = 1'b0;
      reg_addr_i = '0;
      reg_wdata_i = '0;
      fe_data_i = '0;
      fe_rxvalid_i = 1'b0;
      fe_rxactive_i = 1'b0;
      repeat (16) @(negedge fe_clk_i);
      rst_n_i = 1'b1;
      @(negedge fe_clk_i);

      // readback and reset status
      check_status();
      wr_reg(REG_DELAY, 8'h5a);
      wr_reg(REG_WIDTH, 8'h07);
      rd_reg(REG_DELAY, d);
      check_eq("delay", d, 8'h5a);
      rd_reg(REG_WIDTH, d);
      check_eq("width", d, 8'h07);

      // random masked matches, one shot per arm
      for (int t = 0; t < 6; t++) begin
         load_random_setup();
         wr_reg(REG_ARM, 8'h01);
         r = $random(seed);
         send_packet(r[2:0] % 6, 1'b1, r[10:6] % 20);
         settle();
         send_packet(2, 1'b1, 3);   // second occurrence after done
         settle();
         check_status();
         drain_check();
      end

      // split across packets, short packet, disarmed
      wr_reg(REG_DELAY, 8'd2);
      wr_reg(REG_WIDTH, 8'd2);
      wr_reg(REG_MASK, 8'h00);   // oldest byte ignored, three bytes alone would hit
      repeat (3) wr_reg(REG_MASK, 8'hff);
      wr_reg(REG_ARM, 8'h01);
      send_byte(rand_byte());
      send_pat(0, 1);
      end_packet();
      send_pat(2, 3);
      send_byte(rand_byte());
      end_packet();
      send_pat(1, 3);
      end_packet();
      settle();
      wr_reg(REG_ARM, 8'h00);
      send_packet(1, 1'b1, 2);
      settle();
      check_status();

      // overflow
      wr_reg(REG_ARM, 8'h01);
      send_packet(0, 1'b1, 24);
      settle();
      check_status();
      drain_check();

      // disarm during delay, then re-arm
      wr_reg(REG_DELAY, 8'd60);
      wr_reg(REG_WIDTH, 8'd3);
      wr_reg(REG_ARM, 8'h01);
      send_packet(0, 1'b1, 3);   // captured bytes left for the re-arm to clear
      wr_reg(REG_ARM, 8'h00);
      settle();
      check_status();
      wr_reg(REG_ARM, 8'h01);
      check_status();
      wr_reg(REG_ARM, 8'h00);

      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hdl
hdl/pw_reg_pkg.sv
hdl/pw_trig_pkg.sv
hdl/pw_ctrl_if.sv
hdl/pw_regs.sv
hdl/pattern_matcher.sv
hdl/trigger_fsm.sv
hdl/trigger_timer.sv
hdl/capture_fifo.sv
hdl/phywhisperer_top.sv
sim/pw_asserts.sv
sim/tb_phywhisperer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the trigger block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
   --top-module tb_phywhisperer -o tb_phywhisperer
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_phywhisperer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
   exit 0
fi
exit 1
